//--- amem_pkg.sv
//////////////////////////////////////////////////////////////////////
// 4k x 32 banked scratchpad built from four 1k x 32 banks
// bank is picked by the top two bits of the 12-bit word address
//////////////////////////////////////////////////////////////////////
package amem_pkg;

   localparam int DATA_WIDTH      = 32;
   localparam int ADDR_WIDTH      = 12;
   localparam int BANK_ADDR_WIDTH = 10;
   localparam int NUM_BANKS       = 4;
   localparam int BANK_SEL_WIDTH  = 2;
   localparam int BANK_WORDS      = 1 << BANK_ADDR_WIDTH;   // words per bank

   typedef logic [DATA_WIDTH-1:0]      word_t;
   typedef logic [ADDR_WIDTH-1:0]      addr_t;
   typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
   typedef logic [BANK_SEL_WIDTH-1:0]  bank_sel_t;

   // one port's request at the top
   typedef struct packed {
      addr_t address;
      word_t data;
      logic  wren;
      logic  rden;
   } port_req_t;

   // one port's request as one bank sees it
   typedef struct packed {
      bank_addr_t address;
      word_t      data;
      logic       wren;
      logic       rden;
   } bank_port_t;

   // bank index from the high address bits
   function automatic bank_sel_t bank_of(input addr_t address);
      return address[ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
   endfunction

   // word offset inside the bank
   function automatic bank_addr_t bank_addr_of(input addr_t address);
      return address[BANK_ADDR_WIDTH-1:0];
   endfunction

endpackage

//--- amem_dpram.sv
//////////////////////////////////////////////////////////////////////
// 1k x 32 dual-port bank, one clock, one write per edge
// port a wins a write clash even at different addresses
// reads are registered and return the old word on a same-cycle write
//////////////////////////////////////////////////////////////////////
module amem_dpram (
   input  logic                 clk_a,
   input  logic                 reset,
   input  amem_pkg::bank_port_t req_a,
   input  amem_pkg::bank_port_t req_b,
   output amem_pkg::word_t      q_a,
   output amem_pkg::word_t      q_b
);
   import amem_pkg::*;

   word_t mem [BANK_WORDS];   // contents are undefined until written

   // single write path, port a first
   always_ff @(posedge clk_a)
   begin
      if (req_a.wren)
      begin
         mem[req_a.address] <= req_a.data;
      end
      else if (req_b.wren)
      begin
         mem[req_b.address] <= req_b.data;   // only when port a is idle
      end
   end

   // port a read register, holds while rden is low
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (req_a.rden)
      begin
         q_a <= mem[req_a.address];   // sampled before this edge's write
      end
   end

   // port b read register
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (req_b.rden)
      begin
         q_b <= mem[req_b.address];
      end
   end

   // addresses are copied to every bank, so only check an enabled one
   a_addr_known_a : assert property (
      @(posedge clk_a) disable iff (reset)
      (req_a.wren || req_a.rden) |-> !$isunknown(req_a.address)
   )
   else
      $error("bank port a enabled with unknown address");

   a_addr_known_b : assert property (
      @(posedge clk_a) disable iff (reset)
      (req_b.wren || req_b.rden) |-> !$isunknown(req_b.address)
   )
   else
      $error("bank port b enabled with unknown address");

endmodule

//--- amem_dispatch.sv
//////////////////////////////////////////////////////////////////////
// combinational split of both port requests into per-bank requests
// a port-b write into the bank port a writes is lost in that bank
//////////////////////////////////////////////////////////////////////
module amem_dispatch (
   input  amem_pkg::port_req_t  port_a,
   input  amem_pkg::port_req_t  port_b,
   output amem_pkg::bank_port_t bank_a [amem_pkg::NUM_BANKS],
   output amem_pkg::bank_port_t bank_b [amem_pkg::NUM_BANKS],
   output logic                 write_dropped
);
   import amem_pkg::*;

   bank_sel_t sel_a;
   bank_sel_t sel_b;

   // per-bank enables of each port
   logic [NUM_BANKS-1:0] wr_a;
   logic [NUM_BANKS-1:0] rd_a;
   logic [NUM_BANKS-1:0] wr_b;
   logic [NUM_BANKS-1:0] rd_b;

   assign sel_a = bank_of(port_a.address);
   assign sel_b = bank_of(port_b.address);

   always_comb
   begin
      for (int i = 0; i < NUM_BANKS; i++)
      begin
         wr_a[i] = port_a.wren && (sel_a == bank_sel_t'(i));
         rd_a[i] = port_a.rden && (sel_a == bank_sel_t'(i));
         wr_b[i] = port_b.wren && (sel_b == bank_sel_t'(i));
         rd_b[i] = port_b.rden && (sel_b == bank_sel_t'(i));
      end
   end

   // address and data fan out to all banks, only the enables are steered
   always_comb
   begin
      for (int i = 0; i < NUM_BANKS; i++)
      begin
         bank_a[i].address = bank_addr_of(port_a.address);
         bank_a[i].data    = port_a.data;
         bank_a[i].wren    = wr_a[i];
         bank_a[i].rden    = rd_a[i];

         bank_b[i].address = bank_addr_of(port_b.address);
         bank_b[i].data    = port_b.data;
         bank_b[i].wren    = wr_b[i];   // bank itself drops it on a clash
         bank_b[i].rden    = rd_b[i];
      end
   end

   // same bank written by both ports in this cycle
   assign write_dropped = port_a.wren && port_b.wren && (sel_a == sel_b);

endmodule

//--- amem_read_steer.sv
//////////////////////////////////////////////////////////////////////
// remembers the bank each port last read and muxes that bank's output
// unread banks hold their outputs, so the result is stable between reads
//////////////////////////////////////////////////////////////////////
module amem_read_steer (
   input  logic                clk_a,
   input  logic                reset,
   input  logic                rden_a,
   input  logic                rden_b,
   input  amem_pkg::bank_sel_t sel_a,
   input  amem_pkg::bank_sel_t sel_b,
   input  amem_pkg::word_t     bank_q_a [amem_pkg::NUM_BANKS],
   input  amem_pkg::word_t     bank_q_b [amem_pkg::NUM_BANKS],
   output amem_pkg::word_t     q_a,
   output amem_pkg::word_t     q_b
);
   import amem_pkg::*;

   bank_sel_t sel_q_a;   // bank of the last port-a read
   bank_sel_t sel_q_b;

   // lines up with the bank read register
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         sel_q_a <= '0;
      end
      else if (rden_a)
      begin
         sel_q_a <= sel_a;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         sel_q_b <= '0;
      end
      else if (rden_b)
      begin
         sel_q_b <= sel_b;
      end
   end

   assign q_a = bank_q_a[sel_q_a];
   assign q_b = bank_q_b[sel_q_b];

   // an unknown select would smear X over the read data
   a_sel_known : assert property (
      @(posedge clk_a) disable iff (reset)
      !$isunknown({sel_q_a, sel_q_b})
   )
   else
      $error("read steer select is unknown");

endmodule

//--- amem_top.sv
//////////////////////////////////////////////////////////////////////
// two-port 4k x 32 scratchpad, one-cycle registered reads, no stalls
// write_dropped pulses when both ports write the same bank
//////////////////////////////////////////////////////////////////////
module amem_top (
   input  logic                clk_a,
   input  logic                reset,
   input  amem_pkg::port_req_t port_a,
   input  amem_pkg::port_req_t port_b,
   output amem_pkg::word_t     q_a,
   output amem_pkg::word_t     q_b,
   output logic                write_dropped
);
   import amem_pkg::*;

   bank_port_t bank_a [NUM_BANKS];
   bank_port_t bank_b [NUM_BANKS];
   word_t      bank_q_a [NUM_BANKS];
   word_t      bank_q_b [NUM_BANKS];
   bank_sel_t  sel_a;
   bank_sel_t  sel_b;

   assign sel_a = bank_of(port_a.address);
   assign sel_b = bank_of(port_b.address);

   amem_dispatch i_amem_dispatch (
      .port_a        (port_a),
      .port_b        (port_b),
      .bank_a        (bank_a),
      .bank_b        (bank_b),
      .write_dropped (write_dropped)
   );

   // one 1k bank per address quarter
   for (genvar i = 0; i < NUM_BANKS; i++)
   begin : g_bank
      amem_dpram i_amem_dpram (
         .clk_a (clk_a),
         .reset (reset),
         .req_a (bank_a[i]),
         .req_b (bank_b[i]),
         .q_a   (bank_q_a[i]),
         .q_b   (bank_q_b[i])
      );
   end

   amem_read_steer i_amem_read_steer (
      .clk_a    (clk_a),
      .reset    (reset),
      .rden_a   (port_a.rden),
      .rden_b   (port_b.rden),
      .sel_a    (sel_a),
      .sel_b    (sel_b),
      .bank_q_a (bank_q_a),
      .bank_q_b (bank_q_b),
      .q_a      (q_a),
      .q_b      (q_b)
   );

endmodule

//--- tb_amem.sv
//////////////////////////////////////////////////////////////////////
// self-checking testbench for amem_top, shadow memory as reference
// memory is filled through both ports before any read is checked
//////////////////////////////////////////////////////////////////////
module tb_amem;
   import amem_pkg::*;

   localparam int          CLK_PERIOD      = 10;
   localparam int          RESET_CYCLES    = 4;
   localparam int          SPACE_WORDS     = 1 << ADDR_WIDTH;
   localparam int          FILL_CYCLES     = SPACE_WORDS / 2;
   localparam int          DIRECTED_CYCLES = 100;
   localparam int          RANDOM_CYCLES   = 2000;
   localparam int          MARGIN_CYCLES   = 200;
   localparam int          TIMEOUT         = (RESET_CYCLES + FILL_CYCLES + DIRECTED_CYCLES
                                              + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
   localparam int unsigned RNG_SEED        = 32'hdc199fa7;

   // expected outcome of one clock edge
   typedef struct packed {
      word_t q_a;
      word_t q_b;
      logic  dropped;
   } result_t;

   logic      clk_a;
   logic      reset;
   port_req_t port_a;
   port_req_t port_b;
   word_t     q_a;
   word_t     q_b;
   logic      write_dropped;

   word_t     shadow [SPACE_WORDS];   // expected memory contents
   word_t     exp_q_a;
   word_t     exp_q_b;
   addr_t     hot_list [8] = '{12'h000, 12'h3ff, 12'h400, 12'h401,
                               12'h7ff, 12'h800, 12'hc00, 12'hfff};

   amem_top i_amem_top (
      .clk_a         (clk_a),
      .reset         (reset),
      .port_a        (port_a),
      .port_b        (port_b),
      .q_a           (q_a),
      .q_b           (q_b),
      .write_dropped (write_dropped)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #(CLK_PERIOD / 2) clk_a = ~clk_a;
   end

   // one edge of the memory: reads see old data, port a writes first,
   // port b write lost when both ports write the same bank
   function automatic result_t ref_cycle(input port_req_t a, input port_req_t b,
                                         input word_t cur_q_a, input word_t cur_q_b,
                                         ref word_t mem [SPACE_WORDS]);
      result_t r;
      r.q_a     = a.rden ? mem[a.address] : cur_q_a;
      r.q_b     = b.rden ? mem[b.address] : cur_q_b;
      r.dropped = a.wren && b.wren && (a.address[11:10] == b.address[11:10]);
      if (a.wren)
         mem[a.address] = a.data;
      if (b.wren && !r.dropped)
         mem[b.address] = b.data;
      return r;
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t expected);
      if (got !== expected)
      begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
         $display("Errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic word_t fill_word(input addr_t a);
      return {4'ha, a, 4'h5, ~a};   // unique per address
   endfunction

   function automatic port_req_t idle_req();
      port_req_t r;
      r = '0;
      return r;
   endfunction

   function automatic port_req_t write_req(input addr_t a, input word_t d);
      port_req_t r;
      r         = '0;
      r.address = a;
      r.data    = d;
      r.wren    = 1'b1;
      return r;
   endfunction

   function automatic port_req_t read_req(input addr_t a);
      port_req_t r;
      r         = '0;
      r.address = a;
      r.rden    = 1'b1;
      return r;
   endfunction

   // one cycle of requests, driven just after the edge
   task automatic apply(input port_req_t a, input port_req_t b);
      @(posedge clk_a);
      #1;
      port_a = a;
      port_b = b;
   endtask

   task automatic fill_memory();
      for (int k = 0; k < FILL_CYCLES; k++)
      begin
         apply(write_req(addr_t'(k), fill_word(addr_t'(k))),
               write_req(addr_t'(k + FILL_CYCLES), fill_word(addr_t'(k + FILL_CYCLES))));
      end
      apply(idle_req(), idle_req());
   endtask

   task automatic bank_readback();
      addr_t a;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         a = {bank_sel_t'(b), 10'h155};
         apply(write_req(a, word_t'(32'hc0de0000 + b)), idle_req());
         apply(read_req(a), read_req(a));
         apply(idle_req(), write_req(addr_t'(a + 3), word_t'(32'hbeef0000 + b)));
         apply(read_req(addr_t'(a + 3)), read_req(addr_t'(a + 3)));
      end
      apply(idle_req(), idle_req());
   endtask

   // port a keeps its word while others write and read around it
   task automatic read_hold();
      apply(read_req(12'h4a0), read_req(12'hc0f));
      for (int i = 0; i < 6; i++)
      begin
         if (i % 2 == 0)
            apply(write_req(addr_t'(12'h800 + i), word_t'(32'h0a0a0000 + i)),
                  write_req(12'h4a0, word_t'(32'h0b0b0000 + i)));
         else
            apply(write_req(addr_t'(12'h800 + i), word_t'(32'h0c0c0000 + i)),
                  read_req(addr_t'(12'hc00 + i)));
      end
      apply(read_req(12'h4a0), idle_req());
      apply(idle_req(), idle_req());
   endtask

   task automatic write_collisions();
      apply(write_req(12'h010, 32'h11111111), write_req(12'hc20, 32'h22222222));
      apply(read_req(12'h010), read_req(12'hc20));
      apply(write_req(12'h123, 32'haaaa0001), write_req(12'h1f0, 32'hbbbb0002));
      apply(read_req(12'h123), read_req(12'h1f0));   // 1f0 keeps old word
      apply(write_req(12'h777, 32'hcccc0003), write_req(12'h777, 32'hdddd0004));
      apply(read_req(12'h777), read_req(12'h777));
      apply(idle_req(), idle_req());
   endtask

   task automatic read_during_write();
      port_req_t rw;
      rw      = write_req(12'h345, 32'h5eed0001);
      rw.rden = 1'b1;
      apply(rw, idle_req());
      apply(read_req(12'h345), idle_req());
      apply(write_req(12'h9ab, 32'h5eed0002), read_req(12'h9ab));
      apply(idle_req(), read_req(12'h9ab));
      apply(read_req(12'he01), write_req(12'he01, 32'h5eed0003));
      apply(read_req(12'he01), idle_req());
      apply(idle_req(), idle_req());
   endtask

   // mostly hot addresses so reads and writes keep colliding
   function automatic addr_t pick_address();
      logic [31:0] r;
      r = $urandom;
      if (r[1:0] != 2'b00)
         return hot_list[r[4:2]];
      return r[31:20];
   endfunction

   task automatic random_traffic(input int cycles);
      port_req_t a;
      port_req_t b;
      logic [31:0] ctl;
      for (int i = 0; i < cycles; i++)
      begin
         ctl       = $urandom;
         a.address = pick_address();
         a.data    = $urandom;
         a.wren    = ctl[0];
         a.rden    = ctl[1];
         b.address = pick_address();
         b.data    = $urandom;
         b.wren    = ctl[2];
         b.rden    = ctl[3];
         apply(a, b);
      end
      apply(idle_req(), idle_req());
   endtask

   // expected q held one cycle, compared after the edge settles
   initial
   begin : compare_proc
      result_t res;
      exp_q_a = '0;
      exp_q_b = '0;
      forever
      begin
         @(posedge clk_a);
         if (reset)
         begin
            exp_q_a = '0;
            exp_q_b = '0;
            check_value("write_dropped", {31'b0, write_dropped}, '0);
         end
         else
         begin
            res = ref_cycle(port_a, port_b, exp_q_a, exp_q_b, shadow);
            check_value("write_dropped", {31'b0, write_dropped}, {31'b0, res.dropped});
            exp_q_a = res.q_a;
            exp_q_b = res.q_b;
         end
         @(negedge clk_a);
         check_value("q_a", q_a, exp_q_a);
         check_value("q_b", q_b, exp_q_b);
      end
   end

   initial
   begin : watchdog
      #(TIMEOUT);
      $display("Timeout: run did not finish within %0d time units", TIMEOUT);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial
   begin : main
      void'($urandom(RNG_SEED));
      reset     = 1'b1;
      port_a    = '0;
      port_b    = '0;
      repeat (RESET_CYCLES) @(posedge clk_a);
      #1;
      reset = 1'b0;
      apply(idle_req(), idle_req());   // q still zero after reset
      fill_memory();
      bank_readback();
      read_hold();
      write_collisions();
      read_during_write();
      random_traffic(RANDOM_CYCLES);
      repeat (3) @(negedge clk_a);   // let the last compare run
      $display("No errors");
      $finish;
   end

endmodule

//--- filelist.f
amem_pkg.sv
amem_dpram.sv
amem_dispatch.sv
amem_read_steer.sv
amem_top.sv
tb_amem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the amem testbench with Verilator and runs it.
# Exit status is zero only when the testbench reports a clean run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_amem \
   -Mdir obj_dir \
   -o sim_amem

set +e
output=$(./obj_dir/sim_amem 2>&1)
set -e

echo "$output"

if grep -qx "No errors" <<< "$output"; then
   exit 0
else
   exit 1
fi
